// ==== vlog.f ====
hw/uart_pkg.sv
hw/uart_baud_gen.sv
hw/uart_fifo.sv
hw/uart_tx.sv
hw/uart_rx.sv
hw/uart_regs.sv
hw/uart_core.sv
tests/uart_core_tb.sv

// ==== Bender.yml ====
package:
  name: uart_core

sources:
  - hw/uart_pkg.sv
  - hw/uart_baud_gen.sv
  - hw/uart_fifo.sv
  - hw/uart_tx.sv
  - hw/uart_rx.sv
  - hw/uart_regs.sv
  - hw/uart_core.sv
  - target: test
    files:
      - tests/uart_core_tb.sv

// ==== tests/uart_core_tb.sv ====
/*
 * Random-stimulus testbench for the UART core.
 * Drives the register bus and the serial input, decodes the serial output
 * and compares every result with a small model kept in this module.
 */
`default_nettype none

module uart_core_tb
   import uart_pkg::*;
();

   timeunit 1ns;
   timeprecision 1ps;

   localparam int DEPTH = 4;

   logic      app_clk;
   logic      rst;
   logic      reg_cs;
   logic      reg_wr;
   reg_addr_t reg_addr;
   data_t     reg_wdata;
   data_t     reg_rdata;
   logic      reg_ack;
   logic      si;
   logic      so;

   // LCG state
   logic [31:0] rng_state = 32'h56a695d9;

   // Model of the DUT configuration and state
   int         div_cur;
   logic [1:0] par_cur;
   logic       stop2_cur;
   int         tx_level_m;   // Bytes waiting in the TX FIFO
   logic       frm_m;
   logic       par_m;
   logic       ovf_m;
   data_t      rx_q[$];      // Expected RX FIFO content

   uart_core #(.FIFO_DEPTH(DEPTH)) uart_core_i (
      .app_clk_i(app_clk), .rst_i(rst),
      .reg_cs_i(reg_cs), .reg_wr_i(reg_wr), .reg_addr_i(reg_addr), .reg_wdata_i(reg_wdata),
      .reg_rdata_o(reg_rdata), .reg_ack_o(reg_ack),
      .si_i(si), .so_o(so)
   );

   initial begin
      app_clk = 1'b0;
      forever #4 app_clk = ~app_clk;
   end

   // ########################################################################
   // Random numbers and frame rules
   // ########################################################################
   function automatic logic [31:0] next_rand();
      rng_state = rng_state * 32'd1664525 + 32'd1013904223;
      return rng_state;
   endfunction

   // Upper bits only, low LCG bits are weak
   function automatic int rand_range(int lo, int hi);
      return lo + int'((next_rand() >> 16) % (hi - lo + 1));
   endfunction

   function automatic data_t rand_byte();
      return data_t'(next_rand() >> 16);
   endfunction

   // Code 3 means no parity
   function automatic logic par_on(logic [1:0] m);
      return (m == PAR_EVEN) || (m == PAR_ODD);
   endfunction

   // Even parity bit is the XOR of the data, odd is its inverse
   function automatic logic frame_parity(data_t b, logic [1:0] m);
      return (^b) ^ (m == PAR_ODD);
   endfunction

   function automatic data_t expected_status();
      return {3'b000, ovf_m, par_m, frm_m, rx_q.size() == 0, tx_level_m == DEPTH};
   endfunction

   // ########################################################################
   // Compare tasks
   // ########################################################################
   task automatic abort_run();
      $display("Test failed");
      $fatal(1);
   endtask

   task automatic check_data(string name, data_t exp, data_t act);
      if (exp !== act) begin
         $display("Fail %s: expected %02h, actual %02h", name, exp, act);
         abort_run();
      end
   endtask

   task automatic check_status(string name, data_t exp, data_t act);
      if (exp !== act) begin
         $display("Fail %s: expected %08b, actual %08b", name, exp, act);
         abort_run();
      end
   endtask

   task automatic check_count(string name, int exp, data_t act);
      if (data_t'(exp) !== act) begin
         $display("Fail %s: expected %0d, actual %0d", name, exp, act);
         abort_run();
      end
   endtask

   // ########################################################################
   // Bus driver
   // ########################################################################
   task automatic bus_access(input logic wr, input reg_addr_t addr, input data_t wdata,
                             output data_t rdata);
      int waited;
      @(posedge app_clk);
      reg_cs    <= 1'b1;
      reg_wr    <= wr;
      reg_addr  <= addr;
      reg_wdata <= wdata;
      @(posedge app_clk);
      reg_cs <= 1'b0;
      reg_wr <= 1'b0;
      waited = 0;
      // Ack and read data sampled mid-cycle
      @(negedge app_clk);
      while (!reg_ack) begin
         if (waited == 8) begin
            $display("No ack from the register block within 8 cycles");
            abort_run();
         end
         waited++;
         @(negedge app_clk);
      end
      // Ack belongs to the cycle right after the chip select
      check_count("bus ack latency", 0, data_t'(waited));
      rdata = reg_rdata;
   endtask

   task automatic bus_write(input reg_addr_t addr, input data_t wdata);
      data_t dummy;
      bus_access(1'b1, addr, wdata, dummy);
   endtask

   task automatic bus_read(input reg_addr_t addr, output data_t rdata);
      bus_access(1'b0, addr, 8'h00, rdata);
   endtask

   task automatic set_config(logic tx_en, logic rx_en, logic two_stop, logic [1:0] par);
      par_cur   = par;
      stop2_cur = two_stop;
      bus_write(ADDR_CTRL, {3'b000, par, two_stop, rx_en, tx_en});
   endtask

   task automatic set_divisor(int div);
      div_cur = div;
      bus_write(ADDR_BAUD_LO, data_t'(div));
      bus_write(ADDR_BAUD_HI, 8'h00);
   endtask

   task automatic read_check_status(string name);
      data_t got;
      bus_read(ADDR_STATUS, got);
      check_status(name, expected_status(), got);
   endtask

   // ########################################################################
   // Serial line model
   // ########################################################################
   task automatic drive_bit(logic v);
      @(posedge app_clk);
      si <= v;
      repeat (16 * (div_cur + 1) - 1) @(posedge app_clk);
   endtask

   task automatic send_frame(data_t b, logic bad_par, logic bad_stop);
      drive_bit(1'b0);
      for (int i = 0; i < 8; i++) drive_bit(b[i]);
      if (par_on(par_cur)) drive_bit(frame_parity(b, par_cur) ^ bad_par);
      drive_bit(!bad_stop);
      if (stop2_cur) drive_bit(1'b1);
      // Idle gap, a low stop bit looks like a start to the receiver
      drive_bit(1'b1);
   endtask

   // Push happens mid stop bit, so the count is final when the frame ends
   task automatic rx_frame(data_t b, logic bad_par, logic bad_stop);
      data_t cnt;
      send_frame(b, bad_par, bad_stop);
      if (bad_par && par_on(par_cur)) par_m = 1'b1;
      if (bad_stop) frm_m = 1'b1;
      if (rx_q.size() == DEPTH) ovf_m = 1'b1;
      else rx_q.push_back(b);
      bus_read(ADDR_RXCOUNT, cnt);
      check_count("rx count", rx_q.size(), cnt);
   endtask

   task automatic drain_rx(string name);
      data_t got;
      while (rx_q.size() != 0) begin
         bus_read(ADDR_RXDATA, got);
         check_data(name, rx_q.pop_front(), got);
      end
   endtask

   task automatic recv_frame(output data_t b, output logic par_bit, output logic [1:0] stop_bits);
      int bitper;
      int waited;
      bitper = 16 * (div_cur + 1);
      waited = 0;
      @(negedge app_clk);
      while (so) begin
         if (waited == 4 * bitper) begin
            $display("No start bit on so_o within %0d cycles", waited);
            abort_run();
         end
         waited++;
         @(negedge app_clk);
      end
      // Middle of the start bit
      repeat (bitper / 2) @(negedge app_clk);
      check_data("tx start bit", 8'h00, data_t'(so));
      for (int i = 0; i < 8; i++) begin
         repeat (bitper) @(negedge app_clk);
         b[i] = so;
      end
      par_bit = 1'b0;
      if (par_on(par_cur)) begin
         repeat (bitper) @(negedge app_clk);
         par_bit = so;
      end
      repeat (bitper) @(negedge app_clk);
      stop_bits = {1'b0, so};
      if (stop2_cur) begin
         repeat (bitper) @(negedge app_clk);
         stop_bits[1] = so;
      end
   endtask

   task automatic check_tx_frame(data_t exp);
      data_t      got;
      logic       par_bit;
      logic [1:0] stop_bits;
      recv_frame(got, par_bit, stop_bits);
      check_data("tx data", exp, got);
      if (par_on(par_cur)) begin
         check_data("tx parity", data_t'(frame_parity(exp, par_cur)), data_t'(par_bit));
      end
      check_data("tx stop bits", stop2_cur ? 8'h03 : 8'h01, data_t'(stop_bits));
   endtask

   // ########################################################################
   // Test sequences
   // ########################################################################
   task automatic test_config();
      data_t got;
      data_t ctrl;
      data_t lo;
      data_t hi;
      bus_read(ADDR_CTRL, got);
      check_data("ctrl after reset", 8'h00, got);
      check_data("so_o after reset", 8'h01, data_t'(so));
      read_check_status("status after reset");
      for (int n = 0; n < 4; n++) begin
         ctrl = rand_byte();
         lo   = rand_byte();
         hi   = rand_byte();
         bus_write(ADDR_CTRL, ctrl);
         bus_write(ADDR_BAUD_LO, lo);
         bus_write(ADDR_BAUD_HI, hi);
         bus_read(ADDR_CTRL, got);
         check_data("ctrl readback", ctrl & 8'h1f, got);
         bus_read(ADDR_BAUD_LO, got);
         check_data("baud lo readback", lo, got);
         bus_read(ADDR_BAUD_HI, got);
         check_data("baud hi readback", {4'h0, hi[3:0]}, got);
      end
      for (int a = 8; a < 16; a++) begin
         bus_read(reg_addr_t'(a), got);
         check_data("unused address", 8'h00, got);
      end
   endtask

   task automatic test_tx();
      data_t      got;
      data_t      b;
      data_t      sent[$];
      logic [1:0] p;
      logic       s2;
      int         k;
      repeat (6) begin
         set_divisor(rand_range(1, 7));
         p  = 2'(rand_range(0, 3));
         s2 = rand_range(0, 1) != 0;
         set_config(1'b0, 1'b0, s2, p);
         // One byte past the depth checks the dropped write
         k = rand_range(1, DEPTH + 1);
         sent.delete();
         for (int i = 0; i < k; i++) begin
            b = rand_byte();
            bus_write(ADDR_TXDATA, b);
            if (tx_level_m < DEPTH) begin
               sent.push_back(b);
               tx_level_m++;
            end
         end
         bus_read(ADDR_TXFREE, got);
         check_count("tx free before send", DEPTH - tx_level_m, got);
         read_check_status("tx status");
         set_config(1'b1, 1'b0, s2, p);
         while (sent.size() != 0) begin
            check_tx_frame(sent.pop_front());
            tx_level_m--;
         end
         bus_read(ADDR_TXFREE, got);
         check_count("tx free after send", DEPTH - tx_level_m, got);
      end
   endtask

   task automatic test_rx();
      data_t      got;
      logic [1:0] p;
      logic       s2;
      repeat (5) begin
         set_divisor(rand_range(1, 7));
         p  = 2'(rand_range(0, 3));
         s2 = rand_range(0, 1) != 0;
         set_config(1'b0, 1'b1, s2, p);
         repeat (rand_range(1, DEPTH)) rx_frame(rand_byte(), 1'b0, 1'b0);
         drain_rx("rx data");
         bus_read(ADDR_RXCOUNT, got);
         check_count("rx count drained", 0, got);
         // Empty FIFO reads zero
         bus_read(ADDR_RXDATA, got);
         check_data("rx empty read", 8'h00, got);
         read_check_status("rx status");
      end
   endtask

   task automatic test_errors();
      set_divisor(rand_range(1, 7));
      set_config(1'b0, 1'b1, rand_range(0, 1) != 0, 2'(rand_range(1, 2)));
      rx_frame(rand_byte(), 1'b1, 1'b0);
      read_check_status("parity error status");
      rx_frame(rand_byte(), 1'b0, 1'b1);
      read_check_status("framing error status");
      bus_write(ADDR_STATUS, 8'h1c);
      frm_m = 1'b0;
      par_m = 1'b0;
      ovf_m = 1'b0;
      read_check_status("errors cleared");
      drain_rx("error frame data");
      read_check_status("status after error drain");
   endtask

   task automatic test_overflow();
      set_divisor(rand_range(1, 7));
      set_config(1'b0, 1'b1, rand_range(0, 1) != 0, 2'(rand_range(0, 3)));
      repeat (DEPTH + 1) rx_frame(rand_byte(), 1'b0, 1'b0);
      read_check_status("overflow status");
      drain_rx("overflow data");
      bus_write(ADDR_STATUS, 8'h10);
      ovf_m = 1'b0;
      read_check_status("overflow cleared");
   endtask

   task automatic test_tx_disabled();
      data_t      got;
      data_t      b;
      logic [1:0] p;
      logic       s2;
      set_divisor(rand_range(1, 7));
      p  = 2'(rand_range(0, 3));
      s2 = rand_range(0, 1) != 0;
      set_config(1'b0, 1'b0, s2, p);
      b = rand_byte();
      bus_write(ADDR_TXDATA, b);
      tx_level_m++;
      bus_read(ADDR_TXFREE, got);
      check_count("tx free while disabled", DEPTH - tx_level_m, got);
      // Line must stay idle for 20 bit periods
      repeat (20 * 16 * (div_cur + 1)) begin
         @(negedge app_clk);
         check_data("so_o idle while disabled", 8'h01, data_t'(so));
      end
      set_config(1'b1, 1'b0, s2, p);
      check_tx_frame(b);
      tx_level_m--;
      bus_read(ADDR_TXFREE, got);
      check_count("tx free after enable", DEPTH - tx_level_m, got);
   endtask

   initial begin
      reg_cs     = 1'b0;
      reg_wr     = 1'b0;
      reg_addr   = '0;
      reg_wdata  = '0;
      si         = 1'b1;
      rst        = 1'b1;
      div_cur    = 0;
      par_cur    = 2'b00;
      stop2_cur  = 1'b0;
      tx_level_m = 0;
      frm_m      = 1'b0;
      par_m      = 1'b0;
      ovf_m      = 1'b0;
      repeat (16) @(posedge app_clk);
      rst <= 1'b0;
      test_config();
      test_tx();
      test_rx();
      test_errors();
      test_overflow();
      test_tx_disabled();
      $display("Test passed");
      $finish;
   end

endmodule

`default_nettype wire

// ==== hw/uart_core.sv ====
/*
 * UART core top level.
 * Register block, baud tick, TX and RX FIFOs and the two line FSMs,
 * all on app_clk_i.
 */
`default_nettype none

module uart_core
   import uart_pkg::*;
#(
   parameter int FIFO_DEPTH = 16
) (
   input  wire logic      app_clk_i,
   input  wire logic      rst_i,
   input  wire logic      reg_cs_i,
   input  wire logic      reg_wr_i,
   input  wire reg_addr_t reg_addr_i,
   input  wire data_t     reg_wdata_i,
   output data_t          reg_rdata_o,
   output logic           reg_ack_o,
   input  wire logic      si_i,
   output logic           so_o
);

   localparam int CW = $clog2(FIFO_DEPTH) + 1;

   // Configuration levels
   logic      tx_en;
   logic      rx_en;
   logic      stop2;
   parity_e   parity;
   baud_div_t baud_div;
   logic      tick;

   // TX path
   logic          tx_push;
   data_t         tx_wdata;
   logic          tx_pop;
   data_t         tx_rdata;
   logic          tx_full;
   logic          tx_empty;
   logic [CW-1:0] tx_count;

   // RX path
   logic          rx_push;
   data_t         rx_data;
   logic          rx_pop;
   data_t         rx_rdata;
   logic          rx_full;
   logic          rx_empty;
   logic [CW-1:0] rx_count;
   logic          err_frm;
   logic          err_par;
   logic          err_ovf;

   uart_regs #(.FIFO_DEPTH(FIFO_DEPTH)) u_regs (
      .app_clk_i, .rst_i, .reg_cs_i, .reg_wr_i, .reg_addr_i, .reg_wdata_i,
      .reg_rdata_o, .reg_ack_o,
      .tx_en_o(tx_en), .rx_en_o(rx_en), .stop2_o(stop2), .parity_o(parity),
      .baud_div_o(baud_div),
      .tx_push_o(tx_push), .tx_wdata_o(tx_wdata), .tx_full_i(tx_full), .tx_count_i(tx_count),
      .rx_pop_o(rx_pop), .rx_rdata_i(rx_rdata), .rx_empty_i(rx_empty), .rx_count_i(rx_count),
      .err_frm_i(err_frm), .err_par_i(err_par), .err_ovf_i(err_ovf)
   );

   uart_baud_gen u_baud (.app_clk_i, .rst_i, .baud_div_i(baud_div), .tick_o(tick));

   uart_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_tx_fifo (
      .app_clk_i, .rst_i, .push_i(tx_push), .wdata_i(tx_wdata), .pop_i(tx_pop),
      .rdata_o(tx_rdata), .full_o(tx_full), .empty_o(tx_empty), .count_o(tx_count)
   );

   uart_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_rx_fifo (
      .app_clk_i, .rst_i, .push_i(rx_push), .wdata_i(rx_data), .pop_i(rx_pop),
      .rdata_o(rx_rdata), .full_o(rx_full), .empty_o(rx_empty), .count_o(rx_count)
   );

   uart_tx u_tx (
      .app_clk_i, .rst_i, .tick_i(tick), .tx_en_i(tx_en), .stop2_i(stop2), .parity_i(parity),
      .fifo_empty_i(tx_empty), .fifo_data_i(tx_rdata), .fifo_pop_o(tx_pop), .so_o
   );

   uart_rx u_rx (
      .app_clk_i, .rst_i, .tick_i(tick), .rx_en_i(rx_en), .stop2_i(stop2), .parity_i(parity),
      .si_i, .fifo_full_i(rx_full), .push_o(rx_push), .data_o(rx_data),
      .err_frm_o(err_frm), .err_par_o(err_par), .err_ovf_o(err_ovf)
   );

endmodule

`default_nettype wire

// ==== hw/uart_regs.sv ====
/*
 * Register block on the strobe bus.
 * Holds configuration and sticky errors, gives FIFO access, acks each
 * access one cycle after the chip select.
 */
`default_nettype none

module uart_regs
   import uart_pkg::*;
#(
   parameter int FIFO_DEPTH = 16
) (
   input  wire logic                     app_clk_i,
   input  wire logic                     rst_i,
   input  wire logic                     reg_cs_i,
   input  wire logic                     reg_wr_i,
   input  wire reg_addr_t                reg_addr_i,
   input  wire data_t                    reg_wdata_i,
   output data_t                         reg_rdata_o,
   output logic                          reg_ack_o,
   output logic                          tx_en_o,
   output logic                          rx_en_o,
   output logic                          stop2_o,
   output parity_e                       parity_o,
   output baud_div_t                     baud_div_o,
   output logic                          tx_push_o,
   output data_t                         tx_wdata_o,
   input  wire logic                     tx_full_i,
   input  wire logic [$clog2(FIFO_DEPTH):0] tx_count_i,
   output logic                          rx_pop_o,
   input  wire data_t                    rx_rdata_i,
   input  wire logic                     rx_empty_i,
   input  wire logic [$clog2(FIFO_DEPTH):0] rx_count_i,
   input  wire logic                     err_frm_i,
   input  wire logic                     err_par_i,
   input  wire logic                     err_ovf_i
);

   localparam int CW = $clog2(FIFO_DEPTH) + 1;

   logic          wr;
   logic          rd;
   logic          frm_q;
   logic          par_q;
   logic          ovf_q;
   logic [CW-1:0] tx_free;
   data_t         rdata_d;

   assign wr      = reg_cs_i && reg_wr_i;
   assign rd      = reg_cs_i && !reg_wr_i;
   assign tx_free = CW'(FIFO_DEPTH) - tx_count_i;

   // FIFO strobes, a full push or empty pop is dropped
   assign tx_push_o  = wr && (reg_addr_i == ADDR_TXDATA) && !tx_full_i;
   assign tx_wdata_o = reg_wdata_i;
   assign rx_pop_o   = rd && (reg_addr_i == ADDR_RXDATA) && !rx_empty_i;

   // ##########################################################################
   // Configuration and sticky errors
   // ##########################################################################
   always_ff @(posedge app_clk_i) begin
      if (rst_i) begin
         tx_en_o    <= 1'b0;
         rx_en_o    <= 1'b0;
         stop2_o    <= 1'b0;
         parity_o   <= PAR_NONE;
         baud_div_o <= '0;
         frm_q      <= 1'b0;
         par_q      <= 1'b0;
         ovf_q      <= 1'b0;
      end else begin
         if (wr && reg_addr_i == ADDR_CTRL) begin
            tx_en_o  <= reg_wdata_i[0];
            rx_en_o  <= reg_wdata_i[1];
            stop2_o  <= reg_wdata_i[2];
            parity_o <= parity_e'(reg_wdata_i[4:3]);
         end
         if (wr && reg_addr_i == ADDR_BAUD_LO) baud_div_o[7:0]  <= reg_wdata_i;
         if (wr && reg_addr_i == ADDR_BAUD_HI) baud_div_o[11:8] <= reg_wdata_i[3:0];
         // Write one clears, a new error in the same cycle wins
         if (wr && reg_addr_i == ADDR_STATUS) begin
            if (reg_wdata_i[2]) frm_q <= 1'b0;
            if (reg_wdata_i[3]) par_q <= 1'b0;
            if (reg_wdata_i[4]) ovf_q <= 1'b0;
         end
         if (err_frm_i) frm_q <= 1'b1;
         if (err_par_i) par_q <= 1'b1;
         if (err_ovf_i) ovf_q <= 1'b1;
      end
   end

   // Read mux
   always_comb begin
      case (reg_addr_i)
         ADDR_CTRL:    rdata_d = {3'b000, parity_o, stop2_o, rx_en_o, tx_en_o};
         ADDR_BAUD_LO: rdata_d = baud_div_o[7:0];
         ADDR_BAUD_HI: rdata_d = {4'h0, baud_div_o[11:8]};
         ADDR_STATUS:  rdata_d = {3'b000, ovf_q, par_q, frm_q, rx_empty_i, tx_full_i};
         ADDR_RXDATA:  rdata_d = rx_empty_i ? '0 : rx_rdata_i;
         ADDR_TXFREE:  rdata_d = data_t'(tx_free);
         ADDR_RXCOUNT: rdata_d = data_t'(rx_count_i);
         default:      rdata_d = '0;
      endcase
   end

   // Read data holds until the next read
   always_ff @(posedge app_clk_i) begin
      if (rst_i) begin
         reg_ack_o   <= 1'b0;
         reg_rdata_o <= '0;
      end else begin
         reg_ack_o <= reg_cs_i;
         if (rd) reg_rdata_o <= rdata_d;
      end
   end

   ack_after_cs: assert property (@(posedge app_clk_i) disable iff (rst_i)
      reg_cs_i |=> reg_ack_o);

endmodule

`default_nettype wire

// ==== hw/uart_rx.sv ====
/*
 * Receive FSM with input synchronizer, mid-bit sampling and error checks.
 * Pushes each byte at the middle of the first stop bit and flags
 * framing, parity and overflow errors there as one cycle pulses.
 */
`default_nettype none

module uart_rx
   import uart_pkg::*;
(
   input  wire logic    app_clk_i,
   input  wire logic    rst_i,
   input  wire logic    tick_i,
   input  wire logic    rx_en_i,
   input  wire logic    stop2_i,
   input  wire parity_e parity_i,
   input  wire logic    si_i,
   input  wire logic    fifo_full_i,
   output logic         push_o,
   output data_t        data_o,
   output logic         err_frm_o,
   output logic         err_par_o,
   output logic         err_ovf_o
);

   typedef enum logic [2:0] {RX_IDLE, RX_START, RX_DATA, RX_PARITY, RX_STOP} rx_state_e;

   rx_state_e   state_q;
   logic        si_meta_q;
   logic        si_q;        // Synchronized line
   logic  [3:0] tick_cnt_q;  // Ticks since the falling edge
   logic  [2:0] bit_idx_q;
   logic        stop_idx_q;
   logic        par_q;
   logic        par_bad_q;

   logic mid;
   logic par_en;
   logic par_odd;

   assign par_en  = (parity_i == PAR_EVEN) || (parity_i == PAR_ODD);
   assign par_odd = (parity_i == PAR_ODD);
   // Tick 8 of each bit
   assign mid     = tick_i && (tick_cnt_q == 4'd8);

   // Two flop synchronizer, idles high
   always_ff @(posedge app_clk_i) begin
      if (rst_i) begin
         si_meta_q <= 1'b1;
         si_q      <= 1'b1;
      end else begin
         si_meta_q <= si_i;
         si_q      <= si_meta_q;
      end
   end

   always_ff @(posedge app_clk_i) begin
      if (rst_i) begin
         state_q    <= RX_IDLE;
         tick_cnt_q <= '0;
         bit_idx_q  <= '0;
         stop_idx_q <= 1'b0;
         par_q      <= 1'b0;
         par_bad_q  <= 1'b0;
         data_o     <= '0;
         push_o     <= 1'b0;
         err_frm_o  <= 1'b0;
         err_par_o  <= 1'b0;
         err_ovf_o  <= 1'b0;
      end else begin
         // Strobes default low
         push_o    <= 1'b0;
         err_frm_o <= 1'b0;
         err_par_o <= 1'b0;
         err_ovf_o <= 1'b0;
         if (tick_i) begin
            tick_cnt_q <= tick_cnt_q + 4'd1;
            case (state_q)
               RX_IDLE: if (rx_en_i && !si_q) begin
                  // Edge tick counts as tick 0
                  state_q    <= RX_START;
                  tick_cnt_q <= 4'd1;
               end
               RX_START: if (mid) begin
                  if (si_q) begin
                     state_q <= RX_IDLE;   // Glitch, line back high
                  end else begin
                     state_q    <= RX_DATA;
                     bit_idx_q  <= '0;
                     stop_idx_q <= 1'b0;
                     par_q      <= 1'b0;
                     par_bad_q  <= 1'b0;
                  end
               end
               RX_DATA: if (mid) begin
                  data_o    <= {si_q, data_o[7:1]};
                  par_q     <= par_q ^ si_q;
                  bit_idx_q <= bit_idx_q + 3'd1;
                  if (bit_idx_q == 3'd7) state_q <= par_en ? RX_PARITY : RX_STOP;
               end
               RX_PARITY: if (mid) begin
                  par_bad_q <= si_q != (par_q ^ par_odd);
                  state_q   <= RX_STOP;
               end
               RX_STOP: if (mid) begin
                  if (!stop_idx_q) begin
                     // Frame end, byte goes to the FIFO or is lost
                     push_o    <= !fifo_full_i;
                     err_ovf_o <= fifo_full_i;
                     err_frm_o <= !si_q;
                     err_par_o <= par_bad_q;
                  end
                  // Second stop bit is only waited out
                  if (stop2_i && !stop_idx_q) stop_idx_q <= 1'b1;
                  else                        state_q    <= RX_IDLE;
               end
               default: state_q <= RX_IDLE;
            endcase
         end
      end
   end

   push_xor_ovf: assert property (@(posedge app_clk_i) disable iff (rst_i)
      !(push_o && err_ovf_o));

endmodule

`default_nettype wire

// ==== hw/uart_tx.sv ====
/*
 * Transmit FSM, serializes FIFO bytes onto so_o.
 * Frame is start, 8 data bits LSB first, optional parity, one or two stops.
 * Each bit lasts 16 baud ticks.
 */
`default_nettype none

module uart_tx
   import uart_pkg::*;
(
   input  wire logic    app_clk_i,
   input  wire logic    rst_i,
   input  wire logic    tick_i,
   input  wire logic    tx_en_i,
   input  wire logic    stop2_i,
   input  wire parity_e parity_i,
   input  wire logic    fifo_empty_i,
   input  wire data_t   fifo_data_i,
   output logic         fifo_pop_o,
   output logic         so_o
);

   typedef enum logic [2:0] {TX_IDLE, TX_START, TX_DATA, TX_PARITY, TX_STOP} tx_state_e;

   tx_state_e   state_q;
   logic  [3:0] tick_cnt_q;
   logic  [2:0] bit_idx_q;
   logic        stop_idx_q;  // Set during second stop bit
   logic        par_q;       // Running XOR of sent data bits
   data_t       shift_q;

   logic bit_end;
   logic last_stop;
   logic par_en;
   logic par_odd;

   assign par_en    = (parity_i == PAR_EVEN) || (parity_i == PAR_ODD);
   assign par_odd   = (parity_i == PAR_ODD);
   assign bit_end   = tick_i && (tick_cnt_q == 4'd15);
   assign last_stop = (state_q == TX_STOP) && bit_end && (!stop2_i || stop_idx_q);

   // Load from IDLE on any tick, or straight out of the last stop bit
   assign fifo_pop_o = tx_en_i && !fifo_empty_i &&
                       ((state_q == TX_IDLE && tick_i) || last_stop);

   always_ff @(posedge app_clk_i) begin
      if (rst_i) begin
         state_q    <= TX_IDLE;
         tick_cnt_q <= '0;
         bit_idx_q  <= '0;
         stop_idx_q <= 1'b0;
         par_q      <= 1'b0;
         shift_q    <= '0;
         so_o       <= 1'b1;
      end else if (tick_i) begin
         tick_cnt_q <= tick_cnt_q + 4'd1;
         if (fifo_pop_o) begin
            // Start bit goes out now
            state_q    <= TX_START;
            shift_q    <= fifo_data_i;
            tick_cnt_q <= '0;
            bit_idx_q  <= '0;
            stop_idx_q <= 1'b0;
            par_q      <= 1'b0;
            so_o       <= 1'b0;
         end else begin
            case (state_q)
               TX_IDLE: begin
                  tick_cnt_q <= '0;
                  so_o       <= 1'b1;
               end
               TX_START: if (bit_end) begin
                  state_q <= TX_DATA;
                  so_o    <= shift_q[0];
               end
               TX_DATA: if (bit_end) begin
                  shift_q   <= shift_q >> 1;
                  par_q     <= par_q ^ shift_q[0];
                  bit_idx_q <= bit_idx_q + 3'd1;
                  if (bit_idx_q != 3'd7) begin
                     so_o <= shift_q[1];
                  end else if (par_en) begin
                     // Even parity is the XOR of data, odd inverts it
                     state_q <= TX_PARITY;
                     so_o    <= par_q ^ shift_q[0] ^ par_odd;
                  end else begin
                     state_q <= TX_STOP;
                     so_o    <= 1'b1;
                  end
               end
               TX_PARITY: if (bit_end) begin
                  state_q <= TX_STOP;
                  so_o    <= 1'b1;
               end
               TX_STOP: if (bit_end) begin
                  if (!last_stop) stop_idx_q <= 1'b1;
                  else            state_q    <= TX_IDLE;
               end
               default: state_q <= TX_IDLE;
            endcase
         end
      end
   end

endmodule

`default_nettype wire

// ==== hw/uart_fifo.sv ====
/*
 * Single clock FIFO of characters with full, empty and occupancy count.
 * rdata_o always shows the head entry, so pop reads it in the same cycle.
 */
`default_nettype none

module uart_fifo
   import uart_pkg::*;
#(
   parameter int FIFO_DEPTH = 16
) (
   input  wire logic                        app_clk_i,
   input  wire logic                        rst_i,
   input  wire logic                        push_i,
   input  wire data_t                       wdata_i,
   input  wire logic                        pop_i,
   output data_t                            rdata_o,
   output logic                             full_o,
   output logic                             empty_o,
   output logic [$clog2(FIFO_DEPTH):0]      count_o
);

   localparam int AW = $clog2(FIFO_DEPTH);

   data_t          mem_q [FIFO_DEPTH];
   logic  [AW-1:0] wr_ptr_q;
   logic  [AW-1:0] rd_ptr_q;

   // Storage array
   always_ff @(posedge app_clk_i) begin
      if (push_i) begin
         mem_q[wr_ptr_q] <= wdata_i;
      end
   end

   // Pointers and occupancy, wrap is natural at a power of two
   always_ff @(posedge app_clk_i) begin
      if (rst_i) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_o  <= '0;
      end else begin
         if (push_i) wr_ptr_q <= wr_ptr_q + 1'b1;
         if (pop_i)  rd_ptr_q <= rd_ptr_q + 1'b1;
         if (push_i && !pop_i) begin
            count_o <= count_o + 1'b1;
         end else if (pop_i && !push_i) begin
            count_o <= count_o - 1'b1;
         end
      end
   end

   assign rdata_o = mem_q[rd_ptr_q];
   assign full_o  = (count_o == FIFO_DEPTH[AW:0]);
   assign empty_o = (count_o == '0);

   // Producers and consumers must respect the flags
   no_push_full: assert property (@(posedge app_clk_i) disable iff (rst_i) full_o |-> !push_i);
   no_pop_empty: assert property (@(posedge app_clk_i) disable iff (rst_i) empty_o |-> !pop_i);

endmodule

`default_nettype wire

// ==== hw/uart_baud_gen.sv ====
/*
 * 16x baud enable tick generator.
 * Pulses tick_o for one clock every baud_div_i+1 clocks of app_clk_i.
 */
`default_nettype none

module uart_baud_gen
   import uart_pkg::*;
(
   input  wire logic      app_clk_i,
   input  wire logic      rst_i,
   input  wire baud_div_t baud_div_i,
   output logic           tick_o
);

   baud_div_t cnt_q;
   // Last divisor seen, used to spot a rate change
   baud_div_t div_q;

   always_ff @(posedge app_clk_i) begin
      if (rst_i) begin
         cnt_q  <= '0;
         div_q  <= '0;
         tick_o <= 1'b0;
      end else if (baud_div_i != div_q) begin
         // New rate, restart the period from the top
         cnt_q  <= baud_div_i;
         div_q  <= baud_div_i;
         tick_o <= 1'b0;
      end else if (cnt_q == '0) begin
         cnt_q  <= baud_div_i;
         tick_o <= 1'b1;
      end else begin
         cnt_q  <= cnt_q - 1'b1;
         tick_o <= 1'b0;
      end
   end

   // Ticks are isolated pulses unless dividing by one
   tick_single: assert property (@(posedge app_clk_i) disable iff (rst_i)
      (tick_o && baud_div_i != '0) |=> !tick_o);

endmodule

`default_nettype wire

// ==== hw/uart_pkg.sv ====
/*
 * Shared types and register map of the UART core.
 * Imported by every block that needs a character, divisor or address type.
 */
`default_nettype none

package uart_pkg;

   // One character on the line and on the bus
   typedef logic [7:0]  data_t;
   // 16x baud divisor, one tick every baud_div+1 clocks
   typedef logic [11:0] baud_div_t;
   typedef logic [3:0]  reg_addr_t;

   // Parity mode, code 3 is treated as no parity
   typedef enum logic [1:0] {
      PAR_NONE = 2'd0,
      PAR_EVEN = 2'd1,
      PAR_ODD  = 2'd2
   } parity_e;

   // ##########################################################################
   // Register map
   // ##########################################################################
   localparam reg_addr_t ADDR_CTRL    = 4'd0; // Enables, stop bits, parity
   localparam reg_addr_t ADDR_BAUD_LO = 4'd1;
   localparam reg_addr_t ADDR_BAUD_HI = 4'd2; // Low nibble only
   localparam reg_addr_t ADDR_STATUS  = 4'd3; // Write 1 clears error bits
   localparam reg_addr_t ADDR_TXDATA  = 4'd4;
   localparam reg_addr_t ADDR_RXDATA  = 4'd5; // Read pops
   localparam reg_addr_t ADDR_TXFREE  = 4'd6;
   localparam reg_addr_t ADDR_RXCOUNT = 4'd7;

endpackage

`default_nettype wire
